//--- sources.f
verilog/hangmanPkg.sv
verilog/wordLoader.sv
verilog/letterSlot.sv
verilog/guessJudge.sv
verilog/hostDisplay.sv
verilog/hangmanTop.sv
verification/hangmanTb.sv

//--- runSim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps --top-module hangmanTb \
    -f sources.f -o hangmanSim \
    && ./obj_dir/hangmanSim | tee sim.log \
    && ! grep -q "Test failures found" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

//--- verification/hangmanTb.sv
// Directed hangman testbench with reference model, row and state checks and timeout.
`timescale 1ns/1ps
`default_nettype none

module hangmanTb import hangmanPkg::*; ();
    localparam int       cycleLimit = 2000;   // Full run needs well under 500 cycles.
    localparam asciiChar blankChar  = 8'h20;
    localparam asciiChar underChar  = 8'h5F;

    logic         clk = 1'b0;
    logic         nRst;
    logic         loadStrobe;
    asciiChar     loadChar;
    logic         guessStrobe;
    asciiChar     guessChar;
    logic         newGame;
    logic [127:0] top;
    logic [127:0] bottom;
    gameStateT    state;

    asciiChar [0:wordLen-1]     modelWord;
    logic [wordLen-1:0]         modelRevealed;
    asciiChar [0:maxMistakes-1] modelWrong;     // Newest wrong guess last.
    int                         modelMistakes;
    gameStateT                  modelState;
    int                         errorCount = 0;
    int                         cycleCount = 0;

    hangmanTop #(
        .numSlots    (wordLen),
        .mistakeLimit(maxMistakes)
    ) uut (
        .clk        (clk),
        .nRst       (nRst),
        .loadStrobe (loadStrobe),
        .loadChar   (loadChar),
        .guessStrobe(guessStrobe),
        .guessChar  (guessChar),
        .newGame    (newGame),
        .top        (top),
        .bottom     (bottom),
        .state      (state)
    );

    always #20 clk = ~clk;  // 40 ns period.

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the tests did not finish", cycleCount);
            $display("Test failures found");
            $finish;
        end
    end

    function automatic logic [127:0] putChar(logic [127:0] row, int pos, asciiChar ch);
        row[127-8*pos -: 8] = ch;  // Character 0 sits in the top byte.
        return row;
    endfunction

    function automatic logic [127:0] buildTop();
        logic [127:0] row;
        row = {16{blankChar}};
        if (modelState == WON) begin
            row[127-8*6 -: 24] = "Win";
        end else if (modelState == LOST) begin
            row[127-8*6 -: 32] = "Lose";
        end else begin
            for (int k = 0; k < wordLen; k++) begin
                row = putChar(row, 5 + k, modelRevealed[k] ? modelWord[k] : underChar);
            end
        end
        return row;
    endfunction

    function automatic logic [127:0] buildBottom();
        logic [127:0] row;
        row = {16{blankChar}};
        if (modelState == WON || modelState == LOST) begin
            for (int k = 0; k < wordLen; k++) begin
                row = putChar(row, 5 + k, modelWord[k]);
            end
        end else begin
            for (int j = 0; j < maxMistakes; j++) begin
                row = putChar(row, 5 + j, modelWrong[j]);
            end
        end
        return row;
    endfunction

    function automatic void clearModel();
        modelRevealed = '0;
        modelWrong    = {maxMistakes{underChar}};
        modelMistakes = 0;
        modelState    = LOADING;
    endfunction

    function automatic void applyGuess(asciiChar ch);
        logic anyMatch;
        anyMatch = 1'b0;
        if (modelState == PLAYING) begin
            for (int k = 0; k < wordLen; k++) begin
                if (modelWord[k] == ch) begin
                    anyMatch         = 1'b1;
                    modelRevealed[k] = 1'b1;
                end
            end
            if (!anyMatch) begin
                modelWrong    = {modelWrong[1:maxMistakes-1], ch};
                modelMistakes = modelMistakes + 1;
            end
            if (&modelRevealed) begin
                modelState = WON;
            end else if (modelMistakes >= maxMistakes) begin
                modelState = LOST;
            end
        end
    endfunction

    function automatic asciiChar pickWrongLetter();
        asciiChar ch;
        logic     inWord;
        ch     = underChar;
        inWord = 1'b1;
        while (inWord) begin
            ch     = asciiChar'(8'h41 + ($urandom % 26));  // Random capital letter.
            inWord = 1'b0;
            for (int k = 0; k < wordLen; k++) begin
                if (modelWord[k] == ch) begin
                    inWord = 1'b1;
                end
            end
        end
        return ch;
    endfunction

    task automatic checkRow(input string testName, input string rowName,
                            input logic [127:0] expected, input logic [127:0] actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s %s row: expected %h, actual %h",
                     testName, rowName, expected, actual);
        end
    endtask

    task automatic checkState(input string testName, input gameStateT expected,
                              input gameStateT actual);
        if (actual !== expected) begin
            errorCount++;
            $display("Fail %s state: expected %s, actual %s",
                     testName, expected.name(), actual.name());
        end
    endtask

    task automatic checkView(input string testName);
        checkRow(testName, "top", buildTop(), top);
        checkRow(testName, "bottom", buildBottom(), bottom);
        checkState(testName, modelState, state);
    endtask

    task automatic loadWord(input logic [wordLen*8-1:0] word);
        for (int k = 0; k < wordLen; k++) begin
            @(negedge clk);
            loadStrobe = 1'b1;
            loadChar   = word[wordLen*8-1-8*k -: 8];
            modelWord[k] = word[wordLen*8-1-8*k -: 8];
        end
        @(negedge clk);
        loadStrobe = 1'b0;
        repeat (4) @(negedge clk);  // Armed, then PLAYING, then rows settle.
        modelState = PLAYING;
    endtask

    // Sends one guess and checks the rows one cycle early and at the four-cycle latency.
    task automatic sendGuess(input string testName, input asciiChar ch);
        logic [127:0] oldTop;
        logic [127:0] oldBottom;
        oldTop    = buildTop();
        oldBottom = buildBottom();
        @(negedge clk);
        guessStrobe = 1'b1;
        guessChar   = ch;
        @(negedge clk);
        guessStrobe = 1'b0;
        repeat (3) @(negedge clk);
        checkRow(testName, "early top", oldTop, top);
        checkRow(testName, "early bottom", oldBottom, bottom);
        applyGuess(ch);
        @(negedge clk);
        checkView(testName);
    endtask

    task automatic sendBurst(input string testName, input string letters);
        for (int i = 0; i < letters.len(); i++) begin
            @(negedge clk);
            guessStrobe = 1'b1;
            guessChar   = letters[i];
        end
        @(negedge clk);
        guessStrobe = 1'b0;
        repeat (4) @(negedge clk);  // Last guess reaches the rows.
        for (int i = 0; i < letters.len(); i++) begin
            applyGuess(letters[i]);
        end
        checkView(testName);
    endtask

    task automatic startNewGame(input string testName);
        @(negedge clk);
        newGame = 1'b1;
        @(negedge clk);
        newGame = 1'b0;
        repeat (4) @(negedge clk);
        clearModel();
        checkView(testName);
    endtask

    task automatic resetAndLoad();
        checkView("reset");
        loadWord("APPLE");
        checkView("load");
    endtask

    task automatic correctGuesses();
        sendGuess("correct double letter", "P");
        sendGuess("repeated correct", "P");
        sendGuess("correct single letter", "A");
    endtask

    task automatic wrongGuesses();
        sendGuess("first wrong", "Z");
        sendGuess("second wrong", "K");
        sendGuess("repeated wrong", "Z");
    endtask

    task automatic winGame();
        sendGuess("reveal L", "L");
        sendGuess("win", "E");
        sendGuess("guess after win", "Q");
        sendGuess("correct after win", "L");
    endtask

    task automatic loseGame();
        startNewGame("new game before loss");
        loadWord("HOUSE");
        for (int i = 0; i < maxMistakes; i++) begin
            sendGuess("random wrong", pickWrongLetter());
        end
        checkState("lose", LOST, state);
    endtask

    task automatic newWordGame();
        startNewGame("new game");
        loadWord("GRASS");
        checkView("second word load");
        sendBurst("burst mixed", "SZA");
        sendBurst("burst win", "RG");
        checkState("second word win", WON, state);
    endtask

    initial begin
        void'($urandom(67));
        nRst        = 1'b0;
        loadStrobe  = 1'b0;
        loadChar    = '0;
        guessStrobe = 1'b0;
        guessChar   = '0;
        newGame     = 1'b0;
        modelWord   = {wordLen{underChar}};
        clearModel();
        repeat (16) @(negedge clk);
        nRst = 1'b1;
        repeat (2) @(negedge clk);
        resetAndLoad();
        correctGuesses();
        wrongGuesses();
        winGame();
        loseGame();
        newWordGame();
        $display("Summary: %0d errors in %0d cycles", errorCount, cycleCount);
        if (errorCount == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/hangmanTop.sv
// Hangman top level with the loader, the slot array, the judge and the host display.
`timescale 1ns/1ps
`default_nettype none

module hangmanTop import hangmanPkg::*; #(
    parameter int numSlots     = wordLen,
    parameter int mistakeLimit = maxMistakes
) (
    input  logic         clk,
    input  logic         nRst,
    input  logic         loadStrobe,
    input  asciiChar     loadChar,
    input  logic         guessStrobe,
    input  asciiChar     guessChar,
    input  logic         newGame,
    output logic [127:0] top,
    output logic [127:0] bottom,
    output gameStateT    state
);
    slotLoadT                  slotLoad;
    guessT                     guess;
    logic [numSlots*8-1:0]     secretWord;
    logic                      armed;
    slotStatusT [numSlots-1:0] slotStatus;
    gameViewT                  view;
    logic                      gameOver;

    wordLoader #(
        .numSlots(numSlots)
    ) uLoader (
        .clk        (clk),
        .nRst       (nRst),
        .loadStrobe (loadStrobe),
        .loadChar   (loadChar),
        .guessStrobe(guessStrobe),
        .guessChar  (guessChar),
        .newGame    (newGame),
        .gameOver   (gameOver),
        .slotLoad   (slotLoad),
        .guess      (guess),
        .secretWord (secretWord),
        .armed      (armed)
    );

    for (genvar i = 0; i < numSlots; i++) begin : gSlot
        letterSlot uSlot (
            .clk     (clk),
            .nRst    (nRst),
            .slotLoad(slotLoad),
            .guess   (guess),
            .loadEn  (slotLoad.loadEn[i]),  // This slot's select bit.
            .newGame (newGame),
            .status  (slotStatus[i])
        );
    end

    guessJudge #(
        .numSlots    (numSlots),
        .mistakeLimit(mistakeLimit)
    ) uJudge (
        .clk     (clk),
        .nRst    (nRst),
        .armed   (armed),
        .guess   (guess),
        .status  (slotStatus),
        .newGame (newGame),
        .view    (view),
        .gameOver(gameOver)
    );

    hostDisplay #(
        .numSlots    (numSlots),
        .mistakeLimit(mistakeLimit)
    ) uDisplay (
        .clk       (clk),
        .nRst      (nRst),
        .view      (view),
        .secretWord(secretWord),
        .top       (top),
        .bottom    (bottom)
    );

    assign state = view.state;

endmodule

`default_nettype wire

//--- verilog/hostDisplay.sv
// Host display building the registered 16-character top and bottom rows from the game view.
`timescale 1ns/1ps
`default_nettype none

module hostDisplay import hangmanPkg::*; #(
    parameter int numSlots     = wordLen,
    parameter int mistakeLimit = maxMistakes
) (
    input  logic                  clk,
    input  logic                  nRst,
    input  gameViewT              view,
    input  logic [numSlots*8-1:0] secretWord,
    output logic [127:0]          top,
    output logic [127:0]          bottom
);
    localparam int rowChars = 16;
    localparam int wordPos  = 5;   // First word character.
    localparam int textPos  = 6;   // Start of the outcome text.

    localparam asciiChar         blankChar = 8'h20;
    localparam asciiChar         underChar = 8'h5F;
    localparam asciiChar [0:2]   winText   = "Win";
    localparam asciiChar [0:3]   loseText  = "Lose";

    asciiChar [0:numSlots-1]     wordChars;
    asciiChar [0:numSlots-1]     wordRow;
    asciiChar [0:numSlots-1]     wordNext;
    asciiChar [0:mistakeLimit-1] wrongRow;   // Newest wrong guess at the end.
    asciiChar [0:mistakeLimit-1] wrongNext;
    asciiChar [0:rowChars-1]     topNext;
    asciiChar [0:rowChars-1]     bottomNext;

    assign wordChars = secretWord;

    // Running guess state for the next rows.
    always_comb begin
        wordNext  = wordRow;
        wrongNext = wrongRow;
        if (view.state == LOADING) begin
            wordNext  = {numSlots{underChar}};
            wrongNext = {mistakeLimit{underChar}};
        end else begin
            for (int k = 0; k < numSlots; k++) begin
                if (view.hitMask[k]) begin
                    wordNext[k] = view.guessChar;
                end
            end
            if (view.wrongPulse) begin
                wrongNext = {wrongRow[1:mistakeLimit-1], view.guessChar};
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rowChars; i++) begin
            topNext[i]    = blankChar;
            bottomNext[i] = blankChar;
        end
        case (view.state)
            WON: begin
                for (int i = 0; i < 3; i++) begin
                    topNext[textPos+i] = winText[i];
                end
                for (int k = 0; k < numSlots; k++) begin
                    bottomNext[wordPos+k] = wordChars[k];
                end
            end
            LOST: begin
                for (int i = 0; i < 4; i++) begin
                    topNext[textPos+i] = loseText[i];
                end
                for (int k = 0; k < numSlots; k++) begin
                    bottomNext[wordPos+k] = wordChars[k];
                end
            end
            default: begin
                // Loading gives the blank-game pattern here.
                for (int k = 0; k < numSlots; k++) begin
                    topNext[wordPos+k] = wordNext[k];
                end
                for (int j = 0; j < mistakeLimit; j++) begin
                    bottomNext[wordPos+j] = wrongNext[j];
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            top      <= '0;
            bottom   <= '0;
            wordRow  <= {numSlots{underChar}};
            wrongRow <= {mistakeLimit{underChar}};
        end else begin
            top      <= topNext;
            bottom   <= bottomNext;
            wordRow  <= wordNext;
            wrongRow <= wrongNext;
        end
    end

endmodule

`default_nettype wire

//--- verilog/guessJudge.sv
// Guess judge with reveal count, mistake count, hit mask and the game state FSM.
`timescale 1ns/1ps
`default_nettype none

module guessJudge import hangmanPkg::*; #(
    parameter int numSlots     = wordLen,
    parameter int mistakeLimit = maxMistakes
) (
    input  logic                         clk,
    input  logic                         nRst,
    input  logic                         armed,
    input  guessT                        guess,
    input  slotStatusT [numSlots-1:0]    status,
    input  logic                         newGame,
    output gameViewT                     view,
    output logic                         gameOver
);
    gameStateT               stateQ;
    logic                    validD;
    asciiChar                charD;
    asciiChar [numSlots-1:0] revLetter;  // Letters of slots already revealed.
    logic [numSlots-1:0]     hitMaskQ;
    asciiChar                guessCharQ;
    logic                    wrongQ;
    logic [2:0]              correctQ;
    logic [2:0]              mistakeQ;
    logic [numSlots-1:0]     hitBits;
    logic [numSlots-1:0]     revealedBits;
    logic [2:0]              revealCount;
    logic                    seenBefore;
    logic                    wrong;
    logic [2:0]              mistakeNext;

    always_comb begin
        revealCount = '0;
        seenBefore  = 1'b0;
        for (int k = 0; k < numSlots; k++) begin
            hitBits[k]      = status[k].hit;
            revealedBits[k] = status[k].revealed;
            revealCount     = revealCount + {2'b0, status[k].revealed};
            if (status[k].revealed && revLetter[k] == charD) begin
                seenBefore = 1'b1;  // Letter is already on the board.
            end
        end
    end

    assign wrong       = validD && !(|hitBits) && !seenBefore;
    assign mistakeNext = mistakeQ + {2'b0, wrong};

    always_ff @(posedge clk) begin
        charD      <= guess.guessChar;  // Lines up with slot results.
        guessCharQ <= charD;
        for (int k = 0; k < numSlots; k++) begin
            if (status[k].hit) begin
                revLetter[k] <= charD;
            end
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            stateQ   <= LOADING;
            validD   <= 1'b0;
            hitMaskQ <= '0;
            wrongQ   <= 1'b0;
            correctQ <= '0;
            mistakeQ <= '0;
        end else if (newGame) begin
            stateQ   <= LOADING;
            validD   <= 1'b0;
            hitMaskQ <= '0;
            wrongQ   <= 1'b0;
            correctQ <= '0;
            mistakeQ <= '0;
        end else begin
            validD   <= guess.valid;
            hitMaskQ <= hitBits;
            wrongQ   <= wrong;
            correctQ <= revealCount;
            mistakeQ <= mistakeNext;
            case (stateQ)
                LOADING: begin
                    if (armed) begin
                        stateQ <= PLAYING;
                    end
                end
                PLAYING: begin
                    if (&revealedBits) begin
                        stateQ <= WON;
                    end else if (int'(mistakeNext) >= mistakeLimit) begin
                        stateQ <= LOST;
                    end
                end
                default: stateQ <= stateQ;  // Held until a new game.
            endcase
        end
    end

    assign gameOver = (stateQ == WON) || (stateQ == LOST);

    assign view = '{
        state:        stateQ,
        hitMask:      hitMaskQ,
        guessChar:    guessCharQ,
        wrongPulse:   wrongQ,
        correctCount: correctQ,
        mistakeCount: mistakeQ
    };

endmodule

`default_nettype wire

//--- verilog/letterSlot.sv
// Single letter position holding its character, revealed flag and guess compare.
`timescale 1ns/1ps
`default_nettype none

module letterSlot import hangmanPkg::*; (
    input  logic       clk,
    input  logic       nRst,
    input  slotLoadT   slotLoad,
    input  guessT      guess,
    input  logic       loadEn,
    input  logic       newGame,
    output slotStatusT status
);
    asciiChar letter;
    logic     revealedQ;
    logic     hitQ;
    logic     match;

    assign match = guess.valid && (guess.guessChar == letter);

    always_ff @(posedge clk) begin
        if (loadEn) begin
            letter <= slotLoad.loadChar;
        end
    end

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            revealedQ <= 1'b0;
            hitQ      <= 1'b0;
        end else if (newGame) begin
            revealedQ <= 1'b0;
            hitQ      <= 1'b0;
        end else begin
            // Only the first matching guess counts as a hit.
            hitQ <= match && !revealedQ;
            if (loadEn) begin
                revealedQ <= 1'b0;  // Fresh letter.
            end else if (match) begin
                revealedQ <= 1'b1;
            end
        end
    end

    assign status = '{hit: hitQ, revealed: revealedQ};

endmodule

`default_nettype wire

//--- verilog/wordLoader.sv
// Secret word loader with load index, one-hot slot writes and the gated guess pipeline.
`timescale 1ns/1ps
`default_nettype none

module wordLoader import hangmanPkg::*; #(
    parameter int numSlots = wordLen
) (
    input  logic                  clk,
    input  logic                  nRst,
    input  logic                  loadStrobe,
    input  asciiChar              loadChar,
    input  logic                  guessStrobe,
    input  asciiChar              guessChar,
    input  logic                  newGame,
    input  logic                  gameOver,
    output slotLoadT              slotLoad,
    output guessT                 guess,
    output logic [numSlots*8-1:0] secretWord,
    output logic                  armed
);
    typedef enum logic {
        LOADWORD,
        ARMED
    } phaseT;

    phaseT                         phase;
    logic [$clog2(numSlots+1)-1:0] loadIdx;
    logic [numSlots-1:0]           loadEnQ;
    asciiChar                      loadCharQ;
    asciiChar [0:numSlots-1]       wordQ;     // Character 0 is the first letter.
    logic                          strobeQ;
    asciiChar                      sampleQ;
    logic                          validQ;
    asciiChar                      guessCharQ;
    logic                          loadAccept;

    assign loadAccept = loadStrobe && (phase == LOADWORD) && (loadIdx < numSlots);

    always_ff @(posedge clk or negedge nRst) begin
        if (!nRst) begin
            phase   <= LOADWORD;
            loadIdx <= '0;
            loadEnQ <= '0;
            strobeQ <= 1'b0;
            validQ  <= 1'b0;
        end else if (newGame) begin
            phase   <= LOADWORD;
            loadIdx <= '0;
            loadEnQ <= '0;
            strobeQ <= 1'b0;
            validQ  <= 1'b0;
        end else begin
            loadEnQ <= '0;
            if (loadAccept) begin
                loadEnQ <= {{(numSlots-1){1'b0}}, 1'b1} << loadIdx;
                loadIdx <= loadIdx + 1'b1;
            end
            if (phase == LOADWORD && loadIdx == numSlots) begin
                phase   <= ARMED;  // Last slot written this cycle.
                loadIdx <= '0;
            end
            strobeQ <= guessStrobe;
            validQ  <= strobeQ && (phase == ARMED) && !gameOver;
        end
    end

    always_ff @(posedge clk) begin
        if (loadAccept) begin
            loadCharQ      <= loadChar;
            wordQ[loadIdx] <= loadChar;
        end
        sampleQ    <= guessChar;
        guessCharQ <= sampleQ;
    end

    assign slotLoad   = '{loadEn: loadEnQ, loadChar: loadCharQ};
    assign guess      = '{valid: validQ, guessChar: guessCharQ};
    assign secretWord = wordQ;
    assign armed      = (phase == ARMED);

endmodule

`default_nettype wire

//--- verilog/hangmanPkg.sv
// Shared game sizes, character type, state enum and packed structs for the hangman design.
`default_nettype none

package hangmanPkg;

    localparam int wordLen     = 5;  // Letters in the secret word.
    localparam int maxMistakes = 6;  // Mistakes that lose the game.

    typedef logic [7:0] asciiChar;

    typedef enum logic [1:0] {
        LOADING,
        PLAYING,
        WON,
        LOST
    } gameStateT;

    // Loader to slots, one slot written per load.
    typedef struct packed {
        logic [wordLen-1:0] loadEn;    // One-hot slot select.
        asciiChar           loadChar;
    } slotLoadT;

    typedef struct packed {
        logic     valid;
        asciiChar guessChar;
    } guessT;

    typedef struct packed {
        logic hit;       // First match of this slot's letter.
        logic revealed;  // Letter already guessed.
    } slotStatusT;

    // Judge to display.
    typedef struct packed {
        gameStateT          state;
        logic [wordLen-1:0] hitMask;
        asciiChar           guessChar;
        logic               wrongPulse;
        logic [2:0]         correctCount;
        logic [2:0]         mistakeCount;
    } gameViewT;

endpackage

`default_nettype wire
